//--- Bender.yml
package:
  name: exec_cluster

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/core_pkg.sv
      - verilog/phys_regfile.sv
      - verilog/operand_mux.sv
      - verilog/alu.sv
      - verilog/issue_ctrl.sv
      - verilog/exec_cluster.sv
  - target: simulation
    files:
      - dv/exec_cluster_checker.sv
      - dv/exec_cluster_tb.sv

//--- dv/exec_cluster_checker.sv
`default_nettype none

module exec_cluster_checker #(
    parameter int NUM_SLOTS  = core_pkg::NUM_SLOTS,
    parameter int PREG_COUNT = core_pkg::PREG_COUNT
) (
    input  logic                                        clk,
    input  logic                                        rstn,
    input  logic [NUM_SLOTS-1:0]                        issue_valid,
    input  isa_pkg::optype_t [NUM_SLOTS-1:0]            issue_optype,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src1,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src2,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_imm,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_dest,
    input  logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   issue_rob,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_pc,
    input  logic [NUM_SLOTS-1:0]                        done_valid,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_result,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  done_dest,
    input  logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   done_rob,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_pc,
    input  isa_pkg::optype_t [NUM_SLOTS-1:0]            done_optype,
    output int                                          error_count,
    output int                                          check_count,
    output int                                          pending
);

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0]                 due;
        logic [7:0]                  slot;
        logic [isa_pkg::XLEN-1:0]    result;
        logic [core_pkg::PREG_W-1:0] dest;
        logic [core_pkg::ROB_W-1:0]  rob;
        logic [isa_pkg::XLEN-1:0]    pc;
        logic [3:0]                  optype;
    } completion_t;

    logic [isa_pkg::XLEN-1:0] shadow [PREG_COUNT];
    completion_t              exp_q [$];
    int unsigned              cycle;
    int                       errs = 0;
    int                       checks = 0;

    function automatic logic [31:0] ref_result(logic [3:0] op, logic [31:0] a,
                                               logic [31:0] b, logic [31:0] imm);
        logic [31:0] r;
        r = '0;
        case (op)
            isa_pkg::op_add:  r = a + b;
            isa_pkg::op_addi: r = a + imm;
            isa_pkg::op_lui:  r = imm;
            isa_pkg::op_ori:  r = a | imm;
            isa_pkg::op_xor:  r = a ^ b;
            isa_pkg::op_srai: begin
                r = a >> imm[4:0];
                // vacated top bits take the sign
                if (a[31]) r = r | ~(32'hffff_ffff >> imm[4:0]);
            end
            isa_pkg::op_lb, isa_pkg::op_lw,
            isa_pkg::op_sb, isa_pkg::op_sw: r = a + imm;
            default: r = '0;
        endcase
        return r;
    endfunction

    // stores hand back an address only
    function automatic logic keeps_result(logic [3:0] op);
        return !(op == isa_pkg::op_sb || op == isa_pkg::op_sw);
    endfunction

    task automatic compare_field(string name, int s, logic [31:0] exp, logic [31:0] got);
        checks++;
        if (exp !== got) begin
            $display("** Error: %s[%0d] expected 0x%08h got 0x%08h", name, s, exp, got);
            errs++;
        end
    endtask

    always @(posedge clk) begin
        completion_t              head;
        completion_t              due_now [NUM_SLOTS];
        logic [NUM_SLOTS-1:0]     due_v;
        logic [isa_pkg::XLEN-1:0] a [NUM_SLOTS];
        logic [isa_pkg::XLEN-1:0] b [NUM_SLOTS];
        if (!rstn) begin
            for (int r = 0; r < PREG_COUNT; r++) begin
                shadow[r] = '0;
            end
            exp_q.delete();
            cycle = 0;
        end else begin
            cycle++;
            due_v = '0;
            while (exp_q.size() > 0 && exp_q[0].due == cycle) begin
                head = exp_q.pop_front();
                due_v[head.slot] = 1'b1;
                due_now[head.slot] = head;
            end
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (due_v[s] && done_valid[s] !== 1'b1) begin
                    $display("missing completion on slot %0d for rob %0d", s, due_now[s].rob);
                    errs++;
                end else if (due_v[s]) begin
                    compare_field("done_result", s, due_now[s].result, done_result[s]);
                    compare_field("done_dest", s, due_now[s].dest, done_dest[s]);
                    compare_field("done_rob", s, due_now[s].rob, done_rob[s]);
                    compare_field("done_pc", s, due_now[s].pc, done_pc[s]);
                    compare_field("done_optype", s, due_now[s].optype, done_optype[s]);
                end else if (done_valid[s] !== 1'b0) begin
                    $display("unexpected completion on slot %0d with rob %0d", s, done_rob[s]);
                    errs++;
                end
            end
            // all sources first, slots of a group never feed each other
            for (int s = 0; s < NUM_SLOTS; s++) begin
                a[s] = shadow[issue_src1[s]];
                b[s] = shadow[issue_src2[s]];
            end
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (issue_valid[s]) begin
                    head.due    = cycle + 2;
                    head.slot   = s;
                    head.result = ref_result(issue_optype[s], a[s], b[s], issue_imm[s]);
                    head.dest   = issue_dest[s];
                    head.rob    = issue_rob[s];
                    head.pc     = issue_pc[s];
                    head.optype = issue_optype[s];
                    exp_q.push_back(head);
                    if (keeps_result(issue_optype[s]) && issue_dest[s] != '0) begin
                        shadow[issue_dest[s]] = head.result;
                    end
                end
            end
        end
        error_count <= errs;
        check_count <= checks;
        pending     <= exp_q.size();
    end

endmodule

`default_nettype wire

//--- dv/exec_cluster_tb.sv
`default_nettype none

module exec_cluster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS    = core_pkg::NUM_SLOTS;
    localparam int PREG_COUNT   = core_pkg::PREG_COUNT;
    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 4;
    localparam int OPS_ROUNDS   = 3;
    localparam int CHAIN_LEN    = 16;
    localparam int CROSS_LEN    = 16;
    localparam int MIX_GROUPS   = 400;
    // groups per test plus a drain of 4 cycles after each of the 6 tests
    localparam int TEST_CYCLES  = (PREG_COUNT / 2 + 2) + (4 + OPS_ROUNDS * 10) + CHAIN_LEN
                                  + CROSS_LEN + 8 + MIX_GROUPS + 6 * 4;

    logic clk = 1'b0;
    logic rstn;
    logic [NUM_SLOTS-1:0]                        issue_valid;
    isa_pkg::optype_t [NUM_SLOTS-1:0]            issue_optype;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src1;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src2;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_imm;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_dest;
    logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   issue_rob;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_pc;
    logic [NUM_SLOTS-1:0]                        done_valid;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_result;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  done_dest;
    logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   done_rob;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_pc;
    isa_pkg::optype_t [NUM_SLOTS-1:0]            done_optype;

    // next group, filled slot by slot before it is sent
    logic [NUM_SLOTS-1:0]                        st_valid = '0;
    isa_pkg::optype_t [NUM_SLOTS-1:0]            st_optype;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  st_src1;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  st_src2;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     st_imm;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  st_dest;
    logic [core_pkg::ROB_W-1:0]                  rob_next = '0;
    logic [isa_pkg::XLEN-1:0]                    pc_next = 32'h0000_1000;

    int seed = 25887;
    int error_count;
    int check_count;
    int pending;
    int err_mark = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_cluster #(
        .NUM_SLOTS  (NUM_SLOTS),
        .PREG_COUNT (PREG_COUNT)
    ) i_exec_cluster (
        .clk (clk), .rstn (rstn),
        .issue_valid (issue_valid), .issue_optype (issue_optype),
        .issue_src1 (issue_src1), .issue_src2 (issue_src2), .issue_imm (issue_imm),
        .issue_dest (issue_dest), .issue_rob (issue_rob), .issue_pc (issue_pc),
        .done_valid (done_valid), .done_result (done_result), .done_dest (done_dest),
        .done_rob (done_rob), .done_pc (done_pc), .done_optype (done_optype)
    );

    exec_cluster_checker #(
        .NUM_SLOTS  (NUM_SLOTS),
        .PREG_COUNT (PREG_COUNT)
    ) i_exec_cluster_checker (
        .clk (clk), .rstn (rstn),
        .issue_valid (issue_valid), .issue_optype (issue_optype),
        .issue_src1 (issue_src1), .issue_src2 (issue_src2), .issue_imm (issue_imm),
        .issue_dest (issue_dest), .issue_rob (issue_rob), .issue_pc (issue_pc),
        .done_valid (done_valid), .done_result (done_result), .done_dest (done_dest),
        .done_rob (done_rob), .done_pc (done_pc), .done_optype (done_optype),
        .error_count (error_count), .check_count (check_count), .pending (pending)
    );

    function automatic int rnd_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] rnd32();
        return $random(seed);
    endfunction

    task automatic stage_op(input int s, input isa_pkg::optype_t op,
                            input logic [core_pkg::PREG_W-1:0] src1, src2,
                            input logic [isa_pkg::XLEN-1:0] imm,
                            input logic [core_pkg::PREG_W-1:0] dest);
        st_valid[s]  = 1'b1;
        st_optype[s] = op;
        st_src1[s]   = src1;
        st_src2[s]   = src2;
        st_imm[s]    = imm;
        st_dest[s]   = dest;
    endtask

    task automatic send_group();
        @(posedge clk);
        issue_valid  <= st_valid;
        issue_optype <= st_optype;
        issue_src1   <= st_src1;
        issue_src2   <= st_src2;
        issue_imm    <= st_imm;
        issue_dest   <= st_dest;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            issue_rob[s] <= rob_next;
            issue_pc[s]  <= pc_next;
            rob_next = rob_next + 1'b1;
            pc_next  = pc_next + 32'd4;
        end
        st_valid = '0;
    endtask

    task automatic finish_test(input string name);
        send_group();
        // pending trails the checker by one edge
        @(posedge clk);
        while (pending != 0) @(posedge clk);
        $display("test %s done, %0d errors", name, error_count - err_mark);
        err_mark = error_count;
    endtask

    task automatic run_reset_reads();
        repeat (2) send_group();
        for (int i = 0; i < PREG_COUNT / 2; i++) begin
            stage_op(0, isa_pkg::op_add, 2 * i, 0, '0, 0);
            stage_op(1, isa_pkg::op_add, 2 * i + 1, 0, '0, 0);
            send_group();
        end
        finish_test("reset");
    endtask

    task automatic run_optypes();
        isa_pkg::optype_t op;
        // p1 holds a negative value for SRAI
        for (int g = 0; g < 4; g++) begin
            stage_op(0, isa_pkg::op_lui, 0, 0, rnd32() | (g == 0 ? 32'h8000_0000 : '0), 1 + 2 * g);
            stage_op(1, isa_pkg::op_lui, 0, 0, rnd32(), 2 + 2 * g);
            send_group();
        end
        for (int r = 0; r < OPS_ROUNDS; r++) begin
            for (int k = 1; k <= 10; k++) begin
                op = isa_pkg::optype_t'(k);
                stage_op(0, op, 1, 1 + rnd_below(8), rnd32(), 9 + rnd_below(27));
                stage_op(1, op, 1 + rnd_below(8), 1 + rnd_below(8), rnd32(), 36 + rnd_below(28));
                send_group();
            end
        end
        finish_test("optypes");
    endtask

    task automatic run_chain_and_cross();
        for (int i = 0; i < CHAIN_LEN; i++) begin
            stage_op(0, isa_pkg::op_addi, 9 + i, 0, rnd_below(2048), 10 + i);
            stage_op(1, isa_pkg::op_addi, 39 + i, 0, rnd_below(2048), 40 + i);
            send_group();
        end
        finish_test("chain");
        // each slot reads what the other slot wrote one cycle earlier
        for (int i = 0; i < CROSS_LEN; i++) begin
            stage_op(0, isa_pkg::op_addi, 39 + i, 0, rnd32(), 10 + i);
            stage_op(1, isa_pkg::op_add, 9 + i, 2, '0, 40 + i);
            send_group();
        end
        finish_test("cross");
    endtask

    task automatic run_no_writeback();
        for (int r = 0; r < 2; r++) begin
            stage_op(0, isa_pkg::op_sb, 1, 0, rnd32(), 5);
            stage_op(1, isa_pkg::op_sw, 2, 0, rnd32(), 6);
            send_group();
            stage_op(0, isa_pkg::op_addi, 1, 0, rnd32(), 0);
            stage_op(1, isa_pkg::op_add, 5, 0, '0, 0);
            send_group();
            stage_op(0, isa_pkg::op_add, 5, 0, '0, 0);
            stage_op(1, isa_pkg::op_add, 0, 0, '0, 0);
            send_group();
            stage_op(0, isa_pkg::op_add, 6, 0, '0, 0);
            stage_op(1, isa_pkg::op_lui, 0, 0, rnd32(), 0);
            send_group();
        end
        finish_test("no_wb");
    endtask

    task automatic run_random_mix();
        logic [core_pkg::PREG_W-1:0] src1 [NUM_SLOTS];
        logic [core_pkg::PREG_W-1:0] src2 [NUM_SLOTS];
        logic [core_pkg::PREG_W-1:0] dest [NUM_SLOTS];
        for (int g = 0; g < MIX_GROUPS; g++) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                src1[s] = rnd_below(PREG_COUNT);
                src2[s] = rnd_below(PREG_COUNT);
                dest[s] = rnd_below(PREG_COUNT);
            end
            if (dest[1] == dest[0]) dest[1] = '0;
            // no slot reads its partner's destination
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (src1[s] == dest[1 - s]) src1[s] = '0;
                if (src2[s] == dest[1 - s]) src2[s] = '0;
            end
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (rnd_below(4) != 0) begin
                    stage_op(s, isa_pkg::optype_t'(1 + rnd_below(10)), src1[s], src2[s],
                             rnd32(), dest[s]);
                end
            end
            send_group();
        end
        finish_test("random");
    endtask

    initial begin
        rstn         <= 1'b0;
        issue_valid  <= '0;
        issue_optype <= isa_pkg::optype_t'(0);
        issue_src1   <= '0;
        issue_src2   <= '0;
        issue_imm    <= '0;
        issue_dest   <= '0;
        issue_rob    <= '0;
        issue_pc     <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        run_reset_reads();
        run_optypes();
        run_chain_and_cross();
        run_no_writeback();
        run_random_mix();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_cluster.f
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/phys_regfile.sv
verilog/operand_mux.sv
verilog/alu.sv
verilog/issue_ctrl.sv
verilog/exec_cluster.sv
dv/exec_cluster_checker.sv
dv/exec_cluster_tb.sv

//--- verilog/alu.sv
`default_nettype none

module alu (
    input  logic                          clk,
    input  logic                          rstn,

    input  logic                          ex_valid,
    input  isa_pkg::optype_t              ex_optype,
    input  logic [isa_pkg::XLEN-1:0]      opa,
    input  logic [isa_pkg::XLEN-1:0]      opb,
    input  logic [isa_pkg::XLEN-1:0]      ex_imm,
    input  logic [core_pkg::PREG_W-1:0]   ex_dest,
    input  logic [core_pkg::ROB_W-1:0]    ex_rob,
    input  logic [isa_pkg::XLEN-1:0]      ex_pc,

    output logic                          done_valid,
    output logic [isa_pkg::XLEN-1:0]      done_result,
    output logic [core_pkg::PREG_W-1:0]   done_dest,
    output logic [core_pkg::ROB_W-1:0]    done_rob,
    output logic [isa_pkg::XLEN-1:0]      done_pc,
    output isa_pkg::optype_t              done_optype
);

    logic [isa_pkg::XLEN-1:0] result;

    always_comb begin
        case (ex_optype)
            isa_pkg::op_add:  result = opa + opb;
            isa_pkg::op_addi: result = opa + ex_imm;
            isa_pkg::op_lui:  result = ex_imm;
            isa_pkg::op_ori:  result = opa | ex_imm;
            isa_pkg::op_xor:  result = opa ^ opb;
            // arithmetic shift, sign bit fills from the top
            isa_pkg::op_srai: result = $signed(opa) >>> ex_imm[4:0];
            // memory ops only form the effective address here
            isa_pkg::op_lb,
            isa_pkg::op_lw,
            isa_pkg::op_sb,
            isa_pkg::op_sw:   result = opa + ex_imm;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_valid <= 1'b0;
        end else begin
            done_valid <= ex_valid;
        end
    end

    // result and tags travel together, qualified by done_valid
    always_ff @(posedge clk) begin
        done_result <= result;
        done_dest   <= ex_dest;
        done_rob    <= ex_rob;
        done_pc     <= ex_pc;
        done_optype <= ex_optype;
    end

    // illegal codes would complete with a zero result and no writeback
    assert property (@(posedge clk) disable iff (!rstn)
        ex_valid |-> isa_pkg::writes_reg(ex_optype)
                     || ex_optype == isa_pkg::op_sb || ex_optype == isa_pkg::op_sw);

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    // issue width, one ALU per slot
    localparam int NUM_SLOTS = 2;

    // physical register file size and tag widths
    localparam int PREG_COUNT = 64;
    localparam int PREG_W     = 6;
    localparam int ROB_W      = 6;

    // operand select: 0 picks the register file, s+1 picks ALU s
    localparam int SEL_RF = 0;

    function automatic int fwd_sel_w(int slots);
        return $clog2(slots + 1);
    endfunction

endpackage

`default_nettype wire

//--- verilog/exec_cluster.sv
`default_nettype none

module exec_cluster #(
    parameter int NUM_SLOTS  = core_pkg::NUM_SLOTS,
    parameter int PREG_COUNT = core_pkg::PREG_COUNT,
    localparam int SEL_W     = core_pkg::fwd_sel_w(NUM_SLOTS)
) (
    input  logic                                        clk,
    input  logic                                        rstn,

    input  logic [NUM_SLOTS-1:0]                        issue_valid,
    input  isa_pkg::optype_t [NUM_SLOTS-1:0]            issue_optype,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src1,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src2,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_imm,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_dest,
    input  logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   issue_rob,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_pc,

    output logic [NUM_SLOTS-1:0]                        done_valid,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_result,
    output logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  done_dest,
    output logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   done_rob,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     done_pc,
    output isa_pkg::optype_t [NUM_SLOTS-1:0]            done_optype
);

    // execute stage
    logic [NUM_SLOTS-1:0]                        ex_valid;
    isa_pkg::optype_t [NUM_SLOTS-1:0]            ex_optype;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     ex_imm;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_dest;
    logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   ex_rob;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     ex_pc;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_src1;
    logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_src2;
    logic [NUM_SLOTS-1:0][SEL_W-1:0]             fwd_sel1;
    logic [NUM_SLOTS-1:0][SEL_W-1:0]             fwd_sel2;

    // operands
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     rf_data1;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     rf_data2;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     opa;
    logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     opb;

    logic [NUM_SLOTS-1:0]                        wb_en;

    issue_ctrl #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_issue_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .issue_valid  (issue_valid),
        .issue_optype (issue_optype),
        .issue_src1   (issue_src1),
        .issue_src2   (issue_src2),
        .issue_imm    (issue_imm),
        .issue_dest   (issue_dest),
        .issue_rob    (issue_rob),
        .issue_pc     (issue_pc),
        .done_valid   (done_valid),
        .done_dest    (done_dest),
        .done_optype  (done_optype),
        .ex_valid     (ex_valid),
        .ex_optype    (ex_optype),
        .ex_imm       (ex_imm),
        .ex_dest      (ex_dest),
        .ex_rob       (ex_rob),
        .ex_pc        (ex_pc),
        .ex_src1      (ex_src1),
        .ex_src2      (ex_src2),
        .fwd_sel1     (fwd_sel1),
        .fwd_sel2     (fwd_sel2),
        .wb_en        (wb_en)
    );

    // completions write straight back
    phys_regfile #(
        .NUM_SLOTS  (NUM_SLOTS),
        .PREG_COUNT (PREG_COUNT)
    ) i_phys_regfile (
        .clk      (clk),
        .rstn     (rstn),
        .rd_addr1 (ex_src1),
        .rd_addr2 (ex_src2),
        .rd_data1 (rf_data1),
        .rd_data2 (rf_data2),
        .wr_en    (wb_en),
        .wr_addr  (done_dest),
        .wr_data  (done_result)
    );

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        operand_mux #(
            .NUM_SLOTS (NUM_SLOTS)
        ) i_operand_mux (
            .fwd_sel1   (fwd_sel1[s]),
            .fwd_sel2   (fwd_sel2[s]),
            .rf_data1   (rf_data1[s]),
            .rf_data2   (rf_data2[s]),
            .fwd_result (done_result),
            .opa        (opa[s]),
            .opb        (opb[s])
        );

        alu i_alu (
            .clk         (clk),
            .rstn        (rstn),
            .ex_valid    (ex_valid[s]),
            .ex_optype   (ex_optype[s]),
            .opa         (opa[s]),
            .opb         (opb[s]),
            .ex_imm      (ex_imm[s]),
            .ex_dest     (ex_dest[s]),
            .ex_rob      (ex_rob[s]),
            .ex_pc       (ex_pc[s]),
            .done_valid  (done_valid[s]),
            .done_result (done_result[s]),
            .done_dest   (done_dest[s]),
            .done_rob    (done_rob[s]),
            .done_pc     (done_pc[s]),
            .done_optype (done_optype[s])
        );
    end

endmodule

`default_nettype wire

//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // datapath and PC width
    localparam int XLEN = 32;

    // micro-op type as presented by the issue logic
    // code 0 and codes above 10 are illegal
    typedef enum logic [3:0] {
        op_add  = 4'd1,
        op_addi = 4'd2,
        op_lui  = 4'd3,
        op_ori  = 4'd4,
        op_xor  = 4'd5,
        op_srai = 4'd6,
        op_lb   = 4'd7,
        op_lw   = 4'd8,
        op_sb   = 4'd9,
        op_sw   = 4'd10
    } optype_t;

    // stores only produce an address, nothing goes back to the register file
    function automatic logic writes_reg(optype_t op);
        return op inside {op_add, op_addi, op_lui, op_ori, op_xor, op_srai, op_lb, op_lw};
    endfunction

endpackage

`default_nettype wire

//--- verilog/issue_ctrl.sv
`default_nettype none

module issue_ctrl #(
    parameter int NUM_SLOTS = core_pkg::NUM_SLOTS,
    localparam int SEL_W    = core_pkg::fwd_sel_w(NUM_SLOTS)
) (
    input  logic                                        clk,
    input  logic                                        rstn,

    input  logic [NUM_SLOTS-1:0]                        issue_valid,
    input  isa_pkg::optype_t [NUM_SLOTS-1:0]            issue_optype,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src1,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_src2,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_imm,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  issue_dest,
    input  logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   issue_rob,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     issue_pc,

    input  logic [NUM_SLOTS-1:0]                        done_valid,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  done_dest,
    input  isa_pkg::optype_t [NUM_SLOTS-1:0]            done_optype,

    output logic [NUM_SLOTS-1:0]                        ex_valid,
    output isa_pkg::optype_t [NUM_SLOTS-1:0]            ex_optype,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     ex_imm,
    output logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_dest,
    output logic [NUM_SLOTS-1:0][core_pkg::ROB_W-1:0]   ex_rob,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     ex_pc,
    output logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_src1,
    output logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  ex_src2,

    output logic [NUM_SLOTS-1:0][SEL_W-1:0]             fwd_sel1,
    output logic [NUM_SLOTS-1:0][SEL_W-1:0]             fwd_sel2,

    output logic [NUM_SLOTS-1:0]                        wb_en
);

    // ops now in execute that will sit on done_* next cycle with a writeback
    logic [NUM_SLOTS-1:0] fwd_live;

    always_comb begin
        for (int p = 0; p < NUM_SLOTS; p++) begin
            fwd_live[p] = ex_valid[p] && isa_pkg::writes_reg(ex_optype[p]) && ex_dest[p] != '0;
            wb_en[p]    = done_valid[p] && isa_pkg::writes_reg(done_optype[p])
                          && done_dest[p] != '0;
        end
    end

    function automatic logic [SEL_W-1:0] fwd_pick(logic [core_pkg::PREG_W-1:0] tag);
        logic [SEL_W-1:0] sel;
        sel = SEL_W'(core_pkg::SEL_RF);
        for (int p = 0; p < NUM_SLOTS; p++) begin
            if (fwd_live[p] && tag == ex_dest[p]) begin
                sel = SEL_W'(p + 1);
            end
        end
        return sel;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ex_valid <= '0;
            fwd_sel1 <= '0;
            fwd_sel2 <= '0;
        end else begin
            ex_valid <= issue_valid;
            for (int s = 0; s < NUM_SLOTS; s++) begin
                fwd_sel1[s] <= fwd_pick(issue_src1[s]);
                fwd_sel2[s] <= fwd_pick(issue_src2[s]);
            end
        end
    end

    // payload only moves when its slot issues
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (issue_valid[s]) begin
                ex_optype[s] <= issue_optype[s];
                ex_imm[s]    <= issue_imm[s];
                ex_dest[s]   <= issue_dest[s];
                ex_rob[s]    <= issue_rob[s];
                ex_pc[s]     <= issue_pc[s];
                ex_src1[s]   <= issue_src1[s];
                ex_src2[s]   <= issue_src2[s];
            end
        end
    end

    // no intra-group dependency and no shared nonzero destination
    for (genvar a = 0; a < NUM_SLOTS; a++) begin : g_grp_a
        for (genvar b = 0; b < NUM_SLOTS; b++) begin : g_grp_b
            if (a != b) begin : g_pair
                assert property (@(posedge clk) disable iff (!rstn)
                    issue_valid[a] && issue_valid[b] && issue_dest[a] != '0
                    && isa_pkg::writes_reg(issue_optype[a])
                    |-> issue_src1[b] != issue_dest[a] && issue_src2[b] != issue_dest[a]);
                assert property (@(posedge clk) disable iff (!rstn)
                    issue_valid[a] && issue_valid[b] && issue_dest[a] != '0
                    |-> issue_dest[b] != issue_dest[a]);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/operand_mux.sv
`default_nettype none

module operand_mux #(
    parameter int NUM_SLOTS = core_pkg::NUM_SLOTS,
    localparam int SEL_W    = core_pkg::fwd_sel_w(NUM_SLOTS)
) (
    input  logic [SEL_W-1:0]                         fwd_sel1,
    input  logic [SEL_W-1:0]                         fwd_sel2,

    input  logic [isa_pkg::XLEN-1:0]                 rf_data1,
    input  logic [isa_pkg::XLEN-1:0]                 rf_data2,

    // done_result of every ALU
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]  fwd_result,

    output logic [isa_pkg::XLEN-1:0]                 opa,
    output logic [isa_pkg::XLEN-1:0]                 opb
);

    function automatic logic [isa_pkg::XLEN-1:0] pick(
        logic [SEL_W-1:0]         sel,
        logic [isa_pkg::XLEN-1:0] rf_val
    );
        logic [isa_pkg::XLEN-1:0] val;
        val = rf_val;
        // sel s+1 means the result of ALU s from the previous cycle
        for (int s = 0; s < NUM_SLOTS; s++) begin
            if (sel == SEL_W'(s + 1)) begin
                val = fwd_result[s];
            end
        end
        return val;
    endfunction

    always_comb begin
        opa = pick(fwd_sel1, rf_data1);
        opb = pick(fwd_sel2, rf_data2);
    end

endmodule

`default_nettype wire

//--- verilog/phys_regfile.sv
`default_nettype none

module phys_regfile #(
    parameter int NUM_SLOTS  = core_pkg::NUM_SLOTS,
    parameter int PREG_COUNT = core_pkg::PREG_COUNT
) (
    input  logic                                        clk,
    input  logic                                        rstn,

    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  rd_addr1,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  rd_addr2,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     rd_data1,
    output logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     rd_data2,

    input  logic [NUM_SLOTS-1:0]                        wr_en,
    input  logic [NUM_SLOTS-1:0][core_pkg::PREG_W-1:0]  wr_addr,
    input  logic [NUM_SLOTS-1:0][isa_pkg::XLEN-1:0]     wr_data
);

    logic [isa_pkg::XLEN-1:0] mem [PREG_COUNT];

    // asynchronous read, p0 is hardwired to zero
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            rd_data1[s] = (rd_addr1[s] == '0) ? '0 : mem[rd_addr1[s]];
            rd_data2[s] = (rd_addr2[s] == '0) ? '0 : mem[rd_addr2[s]];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int r = 0; r < PREG_COUNT; r++) begin
                mem[r] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (wr_en[s] && wr_addr[s] != '0) begin
                    mem[wr_addr[s]] <= wr_data[s];
                end
            end
        end
    end

    // rename never hands out one tag to two ops completing together
    for (genvar a = 0; a < NUM_SLOTS; a++) begin : g_wr_a
        for (genvar b = a + 1; b < NUM_SLOTS; b++) begin : g_wr_b
            assert property (@(posedge clk) disable iff (!rstn)
                wr_en[a] && wr_en[b] && wr_addr[a] != '0 |-> wr_addr[a] != wr_addr[b]);
        end
    end

endmodule

`default_nettype wire
